//--- sources.f
design/socBusPkg.sv
design/busDecoder.sv
design/dataRam.sv
design/cycleCounter.sv
design/segmentGpio.sv
design/socDataBus.sv
dv/socDataBusAssert.sv
dv/tbSocDataBus.sv

//--- dv/tbSocDataBus.sv
module tbSocDataBus import socBusPkg::*; ();

    localparam int CycleLimit = 2000;
    localparam int RamWrites = 20;
    localparam logic [9:0] DramCode = 10'd2;
    localparam logic [9:0] CounterCode = 10'd8;
    localparam logic [9:0] GpioCode = 10'd9;

    logic w_SysClk;
    logic i_rstN;
    logic i_reqValid;
    busReqT i_req;
    logic o_reqReady;
    logic o_rspValid;
    logic [DataWidth-1:0] o_rspData;
    logic i_rspReady;
    logic [2:0] o_7SegEn;
    logic [6:0] o_7SegLed;

    integer seed;
    int cycleCount;
    int tbErrors;
    logic [11:0] ramOffset [RamWrites];
    logic [DataWidth-1:0] rdata;
    logic [DataWidth-1:0] firstRead;
    logic [DataWidth-1:0] segData;

    socDataBus dut0 (
        .w_SysClk  (w_SysClk),
        .i_rstN    (i_rstN),
        .i_reqValid(i_reqValid),
        .i_req     (i_req),
        .o_reqReady(o_reqReady),
        .o_rspValid(o_rspValid),
        .o_rspData (o_rspData),
        .i_rspReady(i_rspReady),
        .o_7SegEn  (o_7SegEn),
        .o_7SegLed (o_7SegLed)
    );

    always #20 w_SysClk = ~w_SysClk;

    function automatic logic [WordAddrWidth-1:0] mapAddr(input logic [2:0] topCode,
            input logic [1:0] mainCode, input logic [2:0] smallCode, input logic [9:0] slave,
            input logic [11:0] offset);
        return {topCode, mainCode, smallCode, slave, offset};
    endfunction

    function automatic logic [WordAddrWidth-1:0] slaveAddr(input logic [9:0] slave,
            input logic [11:0] offset);
        return mapAddr(3'd0, 2'd3, 3'd1, slave, offset);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            tbErrors++;
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expVal, actVal);
        end
    endtask

    // One request, then a random stall of 0 to 3 cycles on the response
    task automatic busAccess(input logic [WordAddrWidth-1:0] addr, input logic [3:0] be,
            input logic wr, input logic [31:0] data, output logic [31:0] readData);
        int stall;
        @(negedge w_SysClk);
        i_req = '{wordAddr: addr, byteEn: be, write: wr, writeData: data};
        i_reqValid = 1'b1;
        while (!o_reqReady) begin
            @(negedge w_SysClk);
        end
        @(negedge w_SysClk);
        i_reqValid = 1'b0;
        while (!o_rspValid) begin
            @(negedge w_SysClk);
        end
        readData = o_rspData;
        stall = {$random(seed)} % 4;
        repeat (stall) @(negedge w_SysClk);
        i_rspReady = 1'b1;
        @(negedge w_SysClk);
        i_rspReady = 1'b0;
    endtask

    task automatic finishRun(input logic timedOut);
        int assertErrors;
        assertErrors = dut0.assert0.errCount;
        $display("assertion errors %0d, testbench errors %0d, timeout %0s",
            assertErrors, tbErrors, timedOut ? "yes" : "no");
        if (assertErrors == 0 && tbErrors == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge w_SysClk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout, the run did not finish within %0d cycles", CycleLimit);
            finishRun(1'b1);
        end
    end

    initial begin
        w_SysClk = 1'b0;
        i_rstN = 1'b0;
        i_reqValid = 1'b0;
        i_req = '0;
        i_rspReady = 1'b0;
        seed = 98;
        cycleCount = 0;
        tbErrors = 0;
        repeat (3) @(posedge w_SysClk);
        @(negedge w_SysClk);
        i_rstN = 1'b1;

        // Full words first so no lane is left unknown
        for (int i = 0; i < RamWrites; i++) begin
            ramOffset[i] = 12'($random(seed));
            busAccess(slaveAddr(DramCode, ramOffset[i]), 4'hf, 1'b1, $random(seed), rdata);
        end
        for (int i = 0; i < RamWrites; i++) begin
            busAccess(slaveAddr(DramCode, ramOffset[i]), 4'($random(seed)), 1'b1,
                $random(seed), rdata);
        end
        for (int i = 0; i < RamWrites; i++) begin
            busAccess(slaveAddr(DramCode, ramOffset[i]), 4'h0, 1'b0, '0, rdata);
        end

        // Unmapped slave, wrong top field, wrong small field
        busAccess(slaveAddr(10'd5, ramOffset[0]), 4'hf, 1'b1, $random(seed), rdata);
        busAccess(slaveAddr(10'd5, ramOffset[0]), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", '0, rdata);
        busAccess(mapAddr(3'd2, 2'd3, 3'd1, DramCode, ramOffset[0]), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", '0, rdata);
        busAccess(mapAddr(3'd0, 2'd3, 3'd4, DramCode, ramOffset[0]), 4'hf, 1'b1,
            $random(seed), rdata);
        busAccess(mapAddr(3'd0, 2'd3, 3'd4, DramCode, ramOffset[0]), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", '0, rdata);
        busAccess(slaveAddr(DramCode, ramOffset[0]), 4'h0, 1'b0, '0, rdata);

        // Counter disabled, enabled, loaded, disabled again
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", 32'd0, rdata);
        repeat (4) @(negedge w_SysClk);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", 32'd0, rdata);
        busAccess(slaveAddr(CounterCode, 12'd1), 4'hf, 1'b1, 32'd1, rdata);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        repeat (5) @(negedge w_SysClk);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'($random(seed)), 1'b1, $random(seed), rdata);
        repeat (3) @(negedge w_SysClk);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        busAccess(slaveAddr(CounterCode, 12'd1), 4'hf, 1'b1, 32'd0, rdata);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, firstRead);
        repeat (4) @(negedge w_SysClk);
        busAccess(slaveAddr(CounterCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", firstRead, rdata);
        busAccess(slaveAddr(CounterCode, 12'd1), 4'h0, 1'b0, '0, rdata);
        busAccess(slaveAddr(CounterCode, 12'd2), 4'h0, 1'b0, '0, rdata);

        // GPIO through lane 0, then a write with lane 0 clear
        segData = $random(seed);
        busAccess(slaveAddr(GpioCode, 12'd0), 4'h1, 1'b1, segData, rdata);
        busAccess(slaveAddr(GpioCode, 12'd1), 4'h1, 1'b1, segData >> 8, rdata);
        checkValue("o_7SegLed", 32'(segData[6:0]), 32'(o_7SegLed));
        checkValue("o_7SegEn", 32'(segData[10:8]), 32'(o_7SegEn));
        busAccess(slaveAddr(GpioCode, 12'd0), 4'he, 1'b1, ~segData, rdata);
        checkValue("o_7SegLed", 32'(segData[6:0]), 32'(o_7SegLed));
        busAccess(slaveAddr(GpioCode, 12'd0), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", 32'(segData[6:0]), rdata);
        busAccess(slaveAddr(GpioCode, 12'd1), 4'h0, 1'b0, '0, rdata);
        checkValue("o_rspData", 32'(segData[10:8]), rdata);

        repeat (3) @(negedge w_SysClk);
        finishRun(1'b0);
    end

endmodule

//--- dv/socDataBusAssert.sv
module socDataBusAssert import socBusPkg::*; #(
    parameter int ramDepth = DefaultRamDepth
) (
    input logic                 w_SysClk,
    input logic                 i_rstN,
    input logic                 i_reqValid,
    input busReqT               i_req,
    input logic                 o_reqReady,
    input logic                 o_rspValid,
    input logic [DataWidth-1:0] o_rspData,
    input logic                 i_rspReady,
    input logic [2:0]           o_7SegEn,
    input logic [6:0]           o_7SegLed
);

    int errCount = 0;
    logic [DataWidth-1:0] ramModel [ramDepth];
    logic [DataWidth-1:0] countModel;
    logic countEnModel;
    logic [6:0] ledModel;
    logic [2:0] digitEnModel;
    logic [DataWidth-1:0] lookup;
    logic [DataWidth-1:0] expData;
    logic accept;
    logic [RegAddrWidth-1:0] offset;
    int ramIndex;
    slaveSelT target;

    assign accept = i_reqValid && o_reqReady;
    assign offset = i_req.wordAddr[RegAddrWidth-1:0];
    assign ramIndex = int'(offset) % ramDepth;

    // Top 29:27, main 26:25, small 24:22, slave 21:12
    always_comb begin
        target = NoSlave;
        if (i_req.wordAddr[29:27] == TopMainPeriph && i_req.wordAddr[26:25] == MainSmallPeriph
                && i_req.wordAddr[24:22] == SmallVsmallPeriph) begin
            if (i_req.wordAddr[21:12] == SlaveDram0) begin
                target = Dram0;
            end else if (i_req.wordAddr[21:12] == SlaveCounter0) begin
                target = Counter0;
            end else if (i_req.wordAddr[21:12] == SlaveGpio0) begin
                target = Gpio0;
            end
        end
    end

    // Expected read value as the request is accepted
    always_comb begin
        lookup = '0;
        if (!i_req.write) begin
            case (target)
                Dram0: lookup = ramModel[ramIndex];
                Counter0: begin
                    if (offset == CounterRegCount) lookup = countModel;
                    if (offset == CounterRegCtrl) lookup = DataWidth'(countEnModel);
                end
                Gpio0: begin
                    if (offset == GpioRegSegment) lookup = DataWidth'(ledModel);
                    if (offset == GpioRegDigitEn) lookup = DataWidth'(digitEnModel);
                end
                default: lookup = '0;
            endcase
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (accept) begin
            expData <= lookup;
        end
        if (accept && i_req.write && target == Dram0) begin
            for (int lane = 0; lane < ByteEnWidth; lane++) begin
                if (i_req.byteEn[lane]) begin
                    ramModel[ramIndex][lane*8 +: 8] <= i_req.writeData[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            countModel <= '0;
            countEnModel <= 1'b0;
            ledModel <= '0;
            digitEnModel <= '0;
        end else begin
            if (accept && i_req.write && target == Counter0 && offset == CounterRegCount) begin
                countModel <= i_req.writeData;
            end else if (countEnModel) begin
                countModel <= countModel + 1'b1;
            end
            if (accept && i_req.write && target == Counter0 && offset == CounterRegCtrl) begin
                countEnModel <= i_req.writeData[0];
            end
            if (accept && i_req.write && target == Gpio0 && i_req.byteEn[0]) begin
                if (offset == GpioRegSegment) ledModel <= i_req.writeData[6:0];
                if (offset == GpioRegDigitEn) digitEnModel <= i_req.writeData[2:0];
            end
        end
    end

    resetState: assert property (@(posedge w_SysClk)
        !i_rstN |=> (!o_rspValid && o_reqReady && o_7SegEn == 3'd0 && o_7SegLed == 7'd0))
        else begin
            errCount++;
            $error("outputs not in their reset state after reset");
        end

    rspTiming: assert property (@(posedge w_SysClk) disable iff (!i_rstN)
        accept |=> (!o_rspValid && !o_reqReady) ##1 o_rspValid)
        else begin
            errCount++;
            $error("response valid not raised on the edge after acceptance");
        end

    rspHold: assert property (@(posedge w_SysClk) disable iff (!i_rstN)
        (o_rspValid && !i_rspReady) |-> !o_reqReady ##1 (o_rspValid && $stable(o_rspData)))
        else begin
            errCount++;
            $error("response changed or request ready while back-pressured");
        end

    rspValue: assert property (@(posedge w_SysClk) disable iff (!i_rstN)
        $rose(o_rspValid) |-> o_rspData == expData)
        else begin
            errCount++;
            $error("FAIL time %0t o_rspData expected %h actual %h", $time,
                $sampled(expData), $sampled(o_rspData));
        end

    ledMatch: assert property (@(posedge w_SysClk) disable iff (!i_rstN)
        o_7SegLed == ledModel)
        else begin
            errCount++;
            $error("FAIL time %0t o_7SegLed expected %h actual %h", $time,
                $sampled(ledModel), $sampled(o_7SegLed));
        end

    digitEnMatch: assert property (@(posedge w_SysClk) disable iff (!i_rstN)
        o_7SegEn == digitEnModel)
        else begin
            errCount++;
            $error("FAIL time %0t o_7SegEn expected %h actual %h", $time,
                $sampled(digitEnModel), $sampled(o_7SegEn));
        end

endmodule

bind socDataBus socDataBusAssert #(
    .ramDepth(ramDepth)
) assert0 (
    .w_SysClk  (w_SysClk),
    .i_rstN    (i_rstN),
    .i_reqValid(i_reqValid),
    .i_req     (i_req),
    .o_reqReady(o_reqReady),
    .o_rspValid(o_rspValid),
    .o_rspData (o_rspData),
    .i_rspReady(i_rspReady),
    .o_7SegEn  (o_7SegEn),
    .o_7SegLed (o_7SegLed)
);

//--- design/socDataBus.sv
module socDataBus import socBusPkg::*; #(
    parameter int ramDepth = DefaultRamDepth
) (
    input  logic                 w_SysClk,
    input  logic                 i_rstN,
    input  logic                 i_reqValid,
    input  busReqT               i_req,
    output logic                 o_reqReady,
    output logic                 o_rspValid,
    output logic [DataWidth-1:0] o_rspData,
    input  logic                 i_rspReady,
    output logic [2:0]           o_7SegEn,
    output logic [6:0]           o_7SegLed
);

    // Shared slave request, one strobe per slave
    slaveReqT slaveReq;
    logic dramSel;
    logic counterSel;
    logic gpioSel;
    logic [DataWidth-1:0] dramData;
    logic [DataWidth-1:0] counterData;
    logic [DataWidth-1:0] gpioData;

    busDecoder decoder0 (
        .w_SysClk     (w_SysClk),
        .i_rstN       (i_rstN),
        .i_reqValid   (i_reqValid),
        .i_req        (i_req),
        .o_reqReady   (o_reqReady),
        .o_rspValid   (o_rspValid),
        .o_rspData    (o_rspData),
        .i_rspReady   (i_rspReady),
        .o_slaveReq   (slaveReq),
        .o_dramSel    (dramSel),
        .o_counterSel (counterSel),
        .o_gpioSel    (gpioSel),
        .i_dramData   (dramData),
        .i_counterData(counterData),
        .i_gpioData   (gpioData)
    );

    dataRam #(
        .ramDepth(ramDepth)
    ) dram0 (
        .w_SysClk  (w_SysClk),
        .i_sel     (dramSel),
        .i_slaveReq(slaveReq),
        .o_readData(dramData)
    );

    cycleCounter counter0 (
        .w_SysClk  (w_SysClk),
        .i_rstN    (i_rstN),
        .i_sel     (counterSel),
        .i_slaveReq(slaveReq),
        .o_readData(counterData)
    );

    segmentGpio gpio0 (
        .w_SysClk  (w_SysClk),
        .i_rstN    (i_rstN),
        .i_sel     (gpioSel),
        .i_slaveReq(slaveReq),
        .o_readData(gpioData),
        .o_7SegEn  (o_7SegEn),
        .o_7SegLed (o_7SegLed)
    );

endmodule

//--- design/segmentGpio.sv
module segmentGpio import socBusPkg::*; (
    input  logic                 w_SysClk,
    input  logic                 i_rstN,
    input  logic                 i_sel,
    input  slaveReqT             i_slaveReq,
    output logic [DataWidth-1:0] o_readData,
    output logic [2:0]           o_7SegEn,
    output logic [6:0]           o_7SegLed
);

    logic laneWrite;
    logic writeSegment;
    logic writeDigitEn;

    // Both registers live in byte lane 0
    assign laneWrite = i_sel && i_slaveReq.write && i_slaveReq.byteEn[0];
    assign writeSegment = laneWrite && (i_slaveReq.regAddr == GpioRegSegment);
    assign writeDigitEn = laneWrite && (i_slaveReq.regAddr == GpioRegDigitEn);

    // Pins come straight off the registers
    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            o_7SegLed <= '0;
            o_7SegEn <= '0;
        end else begin
            if (writeSegment) begin
                o_7SegLed <= i_slaveReq.writeData[6:0];
            end
            if (writeDigitEn) begin
                o_7SegEn <= i_slaveReq.writeData[2:0];
            end
        end
    end

    // Readback zero extended
    always_ff @(posedge w_SysClk) begin
        if (i_sel) begin
            case (i_slaveReq.regAddr)
                GpioRegSegment: o_readData <= DataWidth'(o_7SegLed);
                GpioRegDigitEn: o_readData <= DataWidth'(o_7SegEn);
                default:        o_readData <= '0;
            endcase
        end
    end

endmodule

//--- design/cycleCounter.sv
module cycleCounter import socBusPkg::*; (
    input  logic                 w_SysClk,
    input  logic                 i_rstN,
    input  logic                 i_sel,
    input  slaveReqT             i_slaveReq,
    output logic [DataWidth-1:0] o_readData
);

    logic [DataWidth-1:0] count;
    logic enable;
    logic loadCount;
    logic writeCtrl;

    // Full word writes, byte enables play no part here
    assign loadCount = i_sel && i_slaveReq.write && (i_slaveReq.regAddr == CounterRegCount);
    assign writeCtrl = i_sel && i_slaveReq.write && (i_slaveReq.regAddr == CounterRegCtrl);

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            count <= '0;
            enable <= 1'b0;
        end else begin
            // A load replaces this cycle's increment
            if (loadCount) begin
                count <= i_slaveReq.writeData;
            end else if (enable) begin
                count <= count + 1'b1;
            end
            if (writeCtrl) begin
                enable <= i_slaveReq.writeData[0];
            end
        end
    end

    // Count as it stands at the strobe edge
    always_ff @(posedge w_SysClk) begin
        if (i_sel) begin
            case (i_slaveReq.regAddr)
                CounterRegCount: o_readData <= count;
                CounterRegCtrl:  o_readData <= {{(DataWidth-1){1'b0}}, enable};
                default:         o_readData <= '0;
            endcase
        end
    end

endmodule

//--- design/dataRam.sv
module dataRam import socBusPkg::*; #(
    parameter int ramDepth = DefaultRamDepth
) (
    input  logic                 w_SysClk,
    input  logic                 i_sel,
    input  slaveReqT             i_slaveReq,
    output logic [DataWidth-1:0] o_readData
);

    // Depth is a power of two, higher offset bits alias
    localparam int IndexWidth = $clog2(ramDepth);

    logic [ByteEnWidth-1:0][7:0] mem [ramDepth];
    logic [IndexWidth-1:0] index;
    logic writeEn;

    assign index = i_slaveReq.regAddr[IndexWidth-1:0];
    assign writeEn = i_sel && i_slaveReq.write;

    // Only lanes with their byte enable set are written
    always_ff @(posedge w_SysClk) begin
        if (writeEn) begin
            for (int lane = 0; lane < ByteEnWidth; lane++) begin
                if (i_slaveReq.byteEn[lane]) begin
                    mem[index][lane] <= i_slaveReq.writeData[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read on the strobe edge
    always_ff @(posedge w_SysClk) begin
        if (i_sel) begin
            o_readData <= mem[index];
        end
    end

endmodule

//--- design/busDecoder.sv
module busDecoder import socBusPkg::*; (
    input  logic                 w_SysClk,
    input  logic                 i_rstN,
    input  logic                 i_reqValid,
    input  busReqT               i_req,
    output logic                 o_reqReady,
    output logic                 o_rspValid,
    output logic [DataWidth-1:0] o_rspData,
    input  logic                 i_rspReady,
    output slaveReqT             o_slaveReq,
    output logic                 o_dramSel,
    output logic                 o_counterSel,
    output logic                 o_gpioSel,
    input  logic [DataWidth-1:0] i_dramData,
    input  logic [DataWidth-1:0] i_counterData,
    input  logic [DataWidth-1:0] i_gpioData
);

    // Field positions inside the word address
    localparam int TopLsb = WordAddrWidth - TopSelBits;
    localparam int MainLsb = TopLsb - MainSelBits;
    localparam int SmallLsb = MainLsb - SmallSelBits;
    localparam int VsmallLsb = SmallLsb - VsmallSelBits;

    logic [TopSelBits-1:0] topField;
    logic [MainSelBits-1:0] mainField;
    logic [SmallSelBits-1:0] smallField;
    logic [VsmallSelBits-1:0] vsmallField;
    slaveSelT reqSel;
    logic accept;
    logic pending;
    slaveSelT pendSel;
    logic pendWrite;
    logic [DataWidth-1:0] rspMux;

    assign topField = i_req.wordAddr[WordAddrWidth-1:TopLsb];
    assign mainField = i_req.wordAddr[TopLsb-1:MainLsb];
    assign smallField = i_req.wordAddr[MainLsb-1:SmallLsb];
    assign vsmallField = i_req.wordAddr[SmallLsb-1:VsmallLsb];

    // Top, then main, then small block must all point at the vsmall block
    always_comb begin
        reqSel = NoSlave;
        if (topField == TopMainPeriph && mainField == MainSmallPeriph
                && smallField == SmallVsmallPeriph) begin
            case (vsmallField)
                SlaveDram0:    reqSel = Dram0;
                SlaveCounter0: reqSel = Counter0;
                SlaveGpio0:    reqSel = Gpio0;
                default:       reqSel = NoSlave;
            endcase
        end
    end

    assign o_slaveReq = '{
        regAddr:   i_req.wordAddr[RegAddrWidth-1:0],
        byteEn:    i_req.byteEn,
        write:     i_req.write,
        writeData: i_req.writeData
    };

    // One request in flight, a new one may enter as the old response leaves
    assign o_reqReady = !pending && (!o_rspValid || i_rspReady);
    assign accept = i_reqValid && o_reqReady;

    assign o_dramSel = accept && (reqSel == Dram0);
    assign o_counterSel = accept && (reqSel == Counter0);
    assign o_gpioSel = accept && (reqSel == Gpio0);

    // Unmapped reads and all writes answer zero
    always_comb begin
        if (pendWrite) begin
            rspMux = '0;
        end else begin
            case (pendSel)
                Dram0:    rspMux = i_dramData;
                Counter0: rspMux = i_counterData;
                Gpio0:    rspMux = i_gpioData;
                default:  rspMux = '0;
            endcase
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            pending <= 1'b0;
            o_rspValid <= 1'b0;
        end else begin
            pending <= accept;
            if (pending) begin
                o_rspValid <= 1'b1;
            end else if (i_rspReady) begin
                o_rspValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (accept) begin
            pendSel <= reqSel;
            pendWrite <= i_req.write;
        end
        // Slave data is registered by now
        if (pending) begin
            o_rspData <= rspMux;
        end
    end

endmodule

//--- design/socBusPkg.sv
package socBusPkg;

    // Bus widths
    localparam int WordAddrWidth = 30;
    localparam int DataWidth = 32;
    localparam int ByteEnWidth = 4;
    localparam int RegAddrWidth = 12;

    // Field widths of the hierarchical map, from the top down
    localparam int TopSelBits = 3;
    localparam int MainSelBits = 2;
    localparam int SmallSelBits = 3;
    localparam int VsmallSelBits = 10;

    // Codes along the path to the very small peripheral block
    localparam logic [TopSelBits-1:0] TopMainPeriph = 3'd0;
    localparam logic [MainSelBits-1:0] MainSmallPeriph = 2'd3;
    localparam logic [SmallSelBits-1:0] SmallVsmallPeriph = 3'd1;

    // Slave codes in the very small peripheral field
    localparam logic [VsmallSelBits-1:0] SlaveDram0 = 10'd2;
    localparam logic [VsmallSelBits-1:0] SlaveCounter0 = 10'd8;
    localparam logic [VsmallSelBits-1:0] SlaveGpio0 = 10'd9;

    // Data RAM size in words
    localparam int DefaultRamDepth = 512;

    // COUNTER0 registers
    localparam logic [RegAddrWidth-1:0] CounterRegCount = 12'd0;
    localparam logic [RegAddrWidth-1:0] CounterRegCtrl = 12'd1;

    // GPIO0 registers
    localparam logic [RegAddrWidth-1:0] GpioRegSegment = 12'd0;
    localparam logic [RegAddrWidth-1:0] GpioRegDigitEn = 12'd1;

    // Master request, a read when write is low
    typedef struct packed {
        logic [WordAddrWidth-1:0] wordAddr;
        logic [ByteEnWidth-1:0] byteEn;
        logic write;
        logic [DataWidth-1:0] writeData;
    } busReqT;

    // Request as seen by a slave, offset only
    typedef struct packed {
        logic [RegAddrWidth-1:0] regAddr;
        logic [ByteEnWidth-1:0] byteEn;
        logic write;
        logic [DataWidth-1:0] writeData;
    } slaveReqT;

    typedef enum logic [1:0] {
        NoSlave,
        Dram0,
        Counter0,
        Gpio0
    } slaveSelT;

endpackage
